//--- vlog.f
+incdir+.
mcont_cmd_pkg.sv
chnbuf_pkg.sv
mcont_read_sequencer.sv
mcont_to_chnbuf_reg.sv
chnbuf_channel.sv
chnbuf_readout.sv
chnbuf_top.sv
tb_chnbuf_top.sv

//--- tb_chnbuf_top.sv
//********************
// Testbench for the channel-buffer read path
// Random commands and memory data from a fixed seed are checked against
// a two-page model per channel
// Prints one line per test and a closing summary
//********************
`timescale 1ns/1ps
`include "mcont_settings.svh"

module tb_chnbuf_top;
    import mcont_cmd_pkg::*;
    import chnbuf_pkg::*;

    localparam int DW       = `MCONT_DW;
    localparam int PW       = `PAGE_WORDS;
    localparam int NC       = `NUM_CHN;
    localparam int WAIT_MAX = 200;

    logic          clk;
    logic          rst_nclk;
    logic          cmd_valid;
    mcont_cmd_u    cmd;
    logic          mem_rd_valid;
    logic [DW-1:0] mem_rd_data;
    logic          rd_en;
    chn_t          rd_chn;
    waddr_t        rd_addr;
    logic          page_release;
    logic          busy;
    logic [NC-1:0] page_ready;
    logic          rd_valid;
    logic [DW-1:0] rd_data;

    // Two-entry page FIFO per channel as the page model
    logic [DW-1:0] exp_mem [NC][2][PW];
    int            exp_len [NC][2];
    int            exp_head [NC];
    int            exp_cnt [NC];

    int errors;
    int checks;
    int test_errors;
    int tests_run;
    int tests_ok;
    bit timed_out;

    chnbuf_top u_dut (
        .clk          (clk),
        .rst_nclk     (rst_nclk),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .rd_en        (rd_en),
        .rd_chn       (rd_chn),
        .rd_addr      (rd_addr),
        .page_release (page_release),
        .busy         (busy),
        .page_ready   (page_ready),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

    // 100 ns period
    always #50 clk = ~clk;

    //********************
    // Helpers
    //********************
    // Drive and sample 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input string what, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        timed_out = 1'b1;
        errors++;
        test_errors++;
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (test_errors == 0) begin
            tests_ok++;
        end
        $display("test %0d %s: %s", num, name, (test_errors == 0) ? "ok" : "FAIL");
        test_errors = 0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            note_timeout("busy never dropped after a command");
        end
    endtask

    // Ready level per channel as the model sees it
    task automatic check_ready();
        logic [NC-1:0] exp;
        for (int c = 0; c < NC; c++) begin
            exp[c] = (exp_cnt[c] != 0);
        end
        check_value("page_ready", page_ready, exp);
    endtask

    //********************
    // Command drivers
    //********************
    // Read of wcnt words with random gaps between them
    task automatic run_read(input int chn, input int wcnt);
        int slot;
        int gap;
        slot = (exp_head[chn] + exp_cnt[chn]) % 2;
        cmd         = '0;
        cmd.rd.op   = CMD_READ;
        cmd.rd.chn  = chn_t'(chn);
        cmd.rd.wcnt = WCNT_W'(wcnt);
        cmd_valid   = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
        for (int i = 0; i < wcnt; i++) begin
            gap = $urandom_range(0, 2);
            repeat (gap) next_cycle();
            mem_rd_data  = {$urandom, $urandom};
            mem_rd_valid = 1'b1;
            exp_mem[chn][slot][i] = mem_rd_data;
            next_cycle();
            mem_rd_valid = 1'b0;
        end
        wait_idle();
        // Page closes at the end of the read
        exp_len[chn][slot] = wcnt;
        exp_cnt[chn]++;
    endtask

    // Refresh with memory strobes that channels must ignore
    task automatic run_refresh(input int cycles);
        int n;
        cmd           = '0;
        cmd.rf.op     = CMD_REFRESH;
        cmd.rf.cycles = REF_CNT_W'(cycles);
        cmd_valid     = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
        n = 0;
        while (busy && n < cycles + 4) begin
            mem_rd_valid = ($urandom_range(0, 1) == 1);
            mem_rd_data  = {$urandom, $urandom};
            next_cycle();
            n++;
        end
        mem_rd_valid = 1'b0;
        if (busy) begin
            note_timeout("busy stuck high during refresh");
        end else begin
            check_value("refresh busy cycles", n, cycles);
        end
    endtask

    // One word of the oldest page comes back one cycle after rd_en
    task automatic read_check(input int chn, input int addr);
        int n;
        rd_en   = 1'b1;
        rd_chn  = chn_t'(chn);
        rd_addr = waddr_t'(addr);
        next_cycle();
        rd_en = 1'b0;
        n = 1;
        while (!rd_valid && n < 4) begin
            next_cycle();
            n++;
        end
        if (!rd_valid) begin
            note_timeout("rd_valid never came after rd_en");
        end else begin
            check_value("rd_valid latency", n, 1);
            check_value($sformatf("chn %0d word %0d", chn, addr), rd_data,
                        exp_mem[chn][exp_head[chn]][addr]);
        end
    endtask

    task automatic check_page(input int chn);
        for (int a = 0; a < exp_len[chn][exp_head[chn]]; a++) begin
            read_check(chn, a);
        end
    endtask

    task automatic release_page(input int chn);
        page_release = 1'b1;
        rd_chn       = chn_t'(chn);
        next_cycle();
        page_release  = 1'b0;
        exp_head[chn] = 1 - exp_head[chn];
        exp_cnt[chn]--;
    endtask

    //********************
    // Main sequence
    //********************
    initial begin
        int chn;
        int op;
        void'($urandom(32'h8d89_79d1));
        errors = 0;
        checks = 0;
        test_errors = 0;
        tests_run = 0;
        tests_ok = 0;
        timed_out = 1'b0;
        clk = 1'b0;
        rst_nclk = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        mem_rd_valid = 1'b0;
        mem_rd_data = '0;
        rd_en = 1'b0;
        rd_chn = '0;
        rd_addr = '0;
        page_release = 1'b0;
        for (int c = 0; c < NC; c++) begin
            exp_head[c] = 0;
            exp_cnt[c] = 0;
        end
        repeat (2) @(posedge clk);
        #5;
        rst_nclk = 1'b0;
        next_cycle();

        // Reset state
        check_value("busy", busy, 0);
        check_value("page_ready", page_ready, 0);
        check_value("rd_valid", rd_valid, 0);
        end_test(1, "reset state");

        // Full page to one channel is kept for the refresh test
        chn = $urandom_range(0, NC - 1);
        run_read(chn, PW);
        check_ready();
        check_page(chn);
        end_test(2, "read and readback");

        // Pages must survive the refresh untouched
        if (!timed_out) begin
            run_refresh($urandom_range(3, 20));
            check_ready();
            check_page(chn);
            release_page(chn);
            check_ready();
        end
        end_test(3, "refresh isolation");

        // Both pages of the channel that saw the refresh
        // A word leaked by the refresh would shift the first of them
        if (!timed_out) begin
            run_read(chn, PW);
            run_read(chn, PW);
            check_ready();
            check_page(chn);
            release_page(chn);
            check_ready();
            check_page(chn);
            release_page(chn);
            check_ready();
        end
        end_test(4, "double buffering");

        // Mixed traffic with reads only to channels that have a free page
        for (int k = 0; k < 60 && !timed_out; k++) begin
            op = $urandom_range(0, 9);
            chn = $urandom_range(0, NC - 1);
            if (op < 5) begin
                if (exp_cnt[chn] < 2) begin
                    run_read(chn, $urandom_range(1, PW));
                end
            end else if (op < 6) begin
                run_refresh($urandom_range(1, 8));
            end else if (op < 8) begin
                if (exp_cnt[chn] > 0) begin
                    read_check(chn, $urandom_range(0, exp_len[chn][exp_head[chn]] - 1));
                end
            end else if (exp_cnt[chn] > 0) begin
                check_page(chn);
                release_page(chn);
            end
            check_ready();
        end
        // Drain what is left
        for (int c = 0; c < NC && !timed_out; c++) begin
            repeat (exp_cnt[c]) begin
                check_page(c);
                release_page(c);
            end
        end
        check_ready();
        end_test(5, "random stream");

        $display("summary: %0d tests, %0d passing, %0d checks, %0d errors",
                 tests_run, tests_ok, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- chnbuf_top.sv
//********************
// Read-data path top level
// Sequencer drives the shared bus, NUM_CHN channels listen,
// readout serves the host
//********************
`timescale 1ns/1ps
`include "mcont_settings.svh"

module chnbuf_top (
    input  logic                      clk,
    input  logic                      rst_nclk,
    input  logic                      cmd_valid,
    input  mcont_cmd_pkg::mcont_cmd_u cmd,
    input  logic                      mem_rd_valid,
    input  logic [`MCONT_DW-1:0]      mem_rd_data,
    input  logic                      rd_en,
    input  mcont_cmd_pkg::chn_t       rd_chn,
    input  chnbuf_pkg::waddr_t        rd_addr,
    input  logic                      page_release,
    output logic                      busy,
    output logic [`NUM_CHN-1:0]       page_ready,
    output logic                      rd_valid,
    output logic [`MCONT_DW-1:0]      rd_data
);
    import mcont_cmd_pkg::*;
    import chnbuf_pkg::*;

    // Shared write bus
    logic                 ext_buf_wr;
    logic                 ext_buf_wpage_nxt;
    chn_t                 ext_buf_wchn;
    logic                 ext_buf_wrefresh;
    logic                 ext_buf_wrun;
    logic [`MCONT_DW-1:0] ext_buf_wdata;

    // Per-channel host side
    logic [`NUM_CHN-1:0][`MCONT_DW-1:0] chn_rdata;
    waddr_t [`NUM_CHN-1:0]              chn_rd_addr;
    logic [`NUM_CHN-1:0]                chn_release;

    mcont_read_sequencer u_seq (
        .clk               (clk),
        .rst_nclk          (rst_nclk),
        .cmd_valid         (cmd_valid),
        .cmd               (cmd),
        .mem_rd_valid      (mem_rd_valid),
        .mem_rd_data       (mem_rd_data),
        .busy              (busy),
        .ext_buf_wr        (ext_buf_wr),
        .ext_buf_wpage_nxt (ext_buf_wpage_nxt),
        .ext_buf_wchn      (ext_buf_wchn),
        .ext_buf_wrefresh  (ext_buf_wrefresh),
        .ext_buf_wrun      (ext_buf_wrun),
        .ext_buf_wdata     (ext_buf_wdata)
    );

    for (genvar i = 0; i < `NUM_CHN; i++) begin : g_chn
        chnbuf_channel #(
            .CHN_NUMBER (i)
        ) u_chn (
            .clk               (clk),
            .rst_nclk          (rst_nclk),
            .ext_buf_wr        (ext_buf_wr),
            .ext_buf_wpage_nxt (ext_buf_wpage_nxt),
            .ext_buf_wchn      (ext_buf_wchn),
            .ext_buf_wrefresh  (ext_buf_wrefresh),
            .ext_buf_wrun      (ext_buf_wrun),
            .ext_buf_wdata     (ext_buf_wdata),
            .rd_addr           (chn_rd_addr[i]),
            .page_release      (chn_release[i]),
            .page_ready        (page_ready[i]),
            .rdata             (chn_rdata[i])
        );
    end

    chnbuf_readout u_readout (
        .clk          (clk),
        .rst_nclk     (rst_nclk),
        .rd_en        (rd_en),
        .rd_chn       (rd_chn),
        .rd_addr      (rd_addr),
        .page_release (page_release),
        .chn_rdata    (chn_rdata),
        .chn_rd_addr  (chn_rd_addr),
        .chn_release  (chn_release),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

endmodule

//--- chnbuf_readout.sv
//********************
// Host readout of the channel buffers
// Routes address and release to the selected channel, registers its word
//********************
`timescale 1ns/1ps
`include "mcont_settings.svh"

module chnbuf_readout (
    input  logic                                 clk,
    input  logic                                 rst_nclk,
    input  logic                                 rd_en,
    input  mcont_cmd_pkg::chn_t                  rd_chn,
    input  chnbuf_pkg::waddr_t                   rd_addr,
    input  logic                                 page_release,
    input  logic [`NUM_CHN-1:0][`MCONT_DW-1:0]   chn_rdata,
    output chnbuf_pkg::waddr_t [`NUM_CHN-1:0]    chn_rd_addr,
    output logic [`NUM_CHN-1:0]                  chn_release,
    output logic                                 rd_valid,
    output logic [`MCONT_DW-1:0]                 rd_data
);
    import mcont_cmd_pkg::*;
    import chnbuf_pkg::*;

    // Address only toggles on the selected channel
    always_comb begin
        for (int i = 0; i < `NUM_CHN; i++) begin
            chn_rd_addr[i] = (rd_chn == chn_t'(i)) ? rd_addr : waddr_t'(0);
            chn_release[i] = page_release && (rd_chn == chn_t'(i));
        end
    end

    // Read result one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rst_nclk) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= chn_rdata[rd_chn];
        end
    end

    // Channel must exist when read or released
    a_rd_chn_range: assert property (@(posedge clk) disable iff (rst_nclk)
        (rd_en || page_release) |-> (rd_chn < `NUM_CHN));

endmodule

//--- chnbuf_channel.sv
//********************
// One channel block on the shared bus
// Register stage plus a two-page buffer, filled from the bus and
// read and released by the host one page at a time
//********************
`timescale 1ns/1ps
`include "mcont_settings.svh"

module chnbuf_channel #(
    parameter int CHN_NUMBER = 0
) (
    input  logic                 clk,
    input  logic                 rst_nclk,
    input  logic                 ext_buf_wr,
    input  logic                 ext_buf_wpage_nxt,
    input  mcont_cmd_pkg::chn_t  ext_buf_wchn,
    input  logic                 ext_buf_wrefresh,
    input  logic                 ext_buf_wrun,
    input  logic [`MCONT_DW-1:0] ext_buf_wdata,
    input  chnbuf_pkg::waddr_t   rd_addr,
    input  logic                 page_release,
    output logic                 page_ready,
    output logic [`MCONT_DW-1:0] rdata
);
    import chnbuf_pkg::*;

    logic                 buf_wr_chn;
    logic                 buf_wpage_nxt_chn;
    logic                 buf_run;
    logic [`MCONT_DW-1:0] buf_wdata_chn;
    logic                 wr_en;

    // Two pages back to back, page index on top
    logic [`MCONT_DW-1:0] mem [2*`PAGE_WORDS];

    page_t  wr_page;
    waddr_t wr_addr;
    page_t  rd_page;
    pcnt_t  pcnt;

    mcont_to_chnbuf_reg #(
        .CHN_NUMBER (CHN_NUMBER)
    ) u_reg (
        .rst_nclk          (rst_nclk),
        .clk               (clk),
        .ext_buf_wr        (ext_buf_wr),
        .ext_buf_wpage_nxt (ext_buf_wpage_nxt),
        .ext_buf_wchn      (ext_buf_wchn),
        .ext_buf_wrefresh  (ext_buf_wrefresh),
        .ext_buf_wrun      (ext_buf_wrun),
        .ext_buf_wdata     (ext_buf_wdata),
        .buf_wr_chn        (buf_wr_chn),
        .buf_wpage_nxt_chn (buf_wpage_nxt_chn),
        .buf_run           (buf_run),
        .buf_wdata_chn     (buf_wdata_chn)
    );

    // Words only count inside a read
    assign wr_en = buf_wr_chn && buf_run;

    //********************
    // Page storage
    //********************
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_page, wr_addr}] <= buf_wdata_chn;
        end
    end

    // Host side, combinational
    assign rdata      = mem[{rd_page, rd_addr}];
    assign page_ready = (pcnt != '0);

    //********************
    // Fill and release bookkeeping
    //********************
    always_ff @(posedge clk) begin
        if (rst_nclk) begin
            wr_page <= 1'b0;
            wr_addr <= '0;
            rd_page <= 1'b0;
            pcnt    <= '0;
        end else begin
            if (buf_wpage_nxt_chn) begin
                // Page closed, start the other one
                wr_page <= ~wr_page;
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (page_release) begin
                rd_page <= ~rd_page;
            end
            // Close and release together leave the count
            case ({buf_wpage_nxt_chn, page_release})
                2'b10:   pcnt <= pcnt + 1'b1;
                2'b01:   pcnt <= pcnt - 1'b1;
                default: pcnt <= pcnt;
            endcase
        end
    end

    // No free page left for the incoming word
    a_wr_full: assert property (@(posedge clk) disable iff (rst_nclk)
        wr_en |-> (pcnt != PCNT_FULL));

    // Nothing to release
    a_rel_empty: assert property (@(posedge clk) disable iff (rst_nclk)
        page_release |-> (pcnt != '0));

endmodule

//--- mcont_to_chnbuf_reg.sv
//********************
// Falling-edge register stage between the shared bus and one channel
// Keeps only the traffic addressed to CHN_NUMBER outside refresh
//********************
`timescale 1ns/1ps
`include "mcont_settings.svh"

module mcont_to_chnbuf_reg #(
    parameter int CHN_NUMBER = 0
) (
    input  logic                 rst_nclk,
    input  logic                 clk,
    input  logic                 ext_buf_wr,
    input  logic                 ext_buf_wpage_nxt,
    input  mcont_cmd_pkg::chn_t  ext_buf_wchn,
    input  logic                 ext_buf_wrefresh,
    input  logic                 ext_buf_wrun,
    input  logic [`MCONT_DW-1:0] ext_buf_wdata,
    output logic                 buf_wr_chn,
    output logic                 buf_wpage_nxt_chn,
    output logic                 buf_run,
    output logic [`MCONT_DW-1:0] buf_wdata_chn
);
    import mcont_cmd_pkg::*;

    logic chn_match;
    logic buf_chn_sel;

    // This channel addressed and no refresh on the bus
    assign chn_match = (ext_buf_wchn == chn_t'(CHN_NUMBER)) && !ext_buf_wrefresh;

    // Strobes, half a cycle behind the bus
    always_ff @(negedge clk) begin
        if (rst_nclk) begin
            buf_chn_sel       <= 1'b0;
            buf_wr_chn        <= 1'b0;
            buf_run           <= 1'b0;
            buf_wpage_nxt_chn <= 1'b0;
        end else begin
            buf_chn_sel       <= chn_match;
            // Qualified by the select of the previous cycle
            buf_wr_chn        <= buf_chn_sel && ext_buf_wr;
            buf_run           <= chn_match && ext_buf_wrun;
            buf_wpage_nxt_chn <= chn_match && ext_buf_wpage_nxt;
        end
    end

    // Data only on a qualified write
    always_ff @(negedge clk) begin
        if (buf_chn_sel && ext_buf_wr) begin
            buf_wdata_chn <= ext_buf_wdata;
        end
    end

    // Read and refresh are exclusive on the bus
    a_run_refresh: assert property (@(negedge clk) disable iff (rst_nclk)
        !(ext_buf_wrefresh && ext_buf_wrun));

endmodule

//--- mcont_read_sequencer.sv
//********************
// Read sequencer of the memory controller
// Decodes host commands and streams returned memory words onto
// the shared channel-buffer write bus with its strobes
//********************
`timescale 1ns/1ps
`include "mcont_settings.svh"

module mcont_read_sequencer (
    input  logic                      clk,
    input  logic                      rst_nclk,
    input  logic                      cmd_valid,
    input  mcont_cmd_pkg::mcont_cmd_u cmd,
    input  logic                      mem_rd_valid,
    input  logic [`MCONT_DW-1:0]      mem_rd_data,
    output logic                      busy,
    output logic                      ext_buf_wr,
    output logic                      ext_buf_wpage_nxt,
    output mcont_cmd_pkg::chn_t       ext_buf_wchn,
    output logic                      ext_buf_wrefresh,
    output logic                      ext_buf_wrun,
    output logic [`MCONT_DW-1:0]      ext_buf_wdata
);
    import mcont_cmd_pkg::*;

    // Wide enough to hold PAGE_WORDS itself
    localparam int CNT_W = $clog2(`PAGE_WORDS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_PEND,
        S_REF
    } state_e;

    state_e               state;
    logic [CNT_W-1:0]     word_total;
    logic [CNT_W-1:0]     word_cnt;
    logic [CNT_W-1:0]     word_cnt_nxt;
    logic [REF_CNT_W-1:0] ref_cnt;

    assign word_cnt_nxt = word_cnt + 1'b1;

    //********************
    // Command FSM
    //********************
    always_ff @(posedge clk) begin
        if (rst_nclk) begin
            state             <= S_IDLE;
            busy              <= 1'b0;
            ext_buf_wrun      <= 1'b0;
            ext_buf_wrefresh  <= 1'b0;
            ext_buf_wpage_nxt <= 1'b0;
            ext_buf_wchn      <= '0;
            word_total        <= '0;
            word_cnt          <= '0;
            ref_cnt           <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // Opcode sits in the same bits of both views
                    if (cmd_valid) begin
                        case (cmd.rd.op)
                            CMD_READ: begin
                                state        <= S_READ;
                                busy         <= 1'b1;
                                ext_buf_wrun <= 1'b1;
                                ext_buf_wchn <= cmd.rd.chn;
                                word_total   <= CNT_W'(cmd.rd.wcnt);
                                word_cnt     <= '0;
                            end
                            CMD_REFRESH: begin
                                state            <= S_REF;
                                busy             <= 1'b1;
                                ext_buf_wrefresh <= 1'b1;
                                ref_cnt          <= cmd.rf.cycles;
                            end
                            default: begin
                                state <= S_IDLE;
                            end
                        endcase
                    end
                end
                S_READ: begin
                    // Count words as they go out on the bus
                    if (mem_rd_valid) begin
                        word_cnt <= word_cnt_nxt;
                        if (word_cnt_nxt == word_total) begin
                            state <= S_PEND;
                        end
                    end
                end
                S_PEND: begin
                    // First cycle pulses next-page, second one ends the read
                    if (!ext_buf_wpage_nxt) begin
                        ext_buf_wpage_nxt <= 1'b1;
                    end else begin
                        ext_buf_wpage_nxt <= 1'b0;
                        ext_buf_wrun      <= 1'b0;
                        busy              <= 1'b0;
                        state             <= S_IDLE;
                    end
                end
                S_REF: begin
                    // Zero count behaves as one cycle
                    if (ref_cnt <= REF_CNT_W'(1)) begin
                        ext_buf_wrefresh <= 1'b0;
                        busy             <= 1'b0;
                        state            <= S_IDLE;
                    end else begin
                        ref_cnt <= ref_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    //********************
    // Write strobe and data
    //********************
    // Not filtered during refresh, channels drop those
    always_ff @(posedge clk) begin
        if (rst_nclk) begin
            ext_buf_wr <= 1'b0;
        end else begin
            ext_buf_wr <= busy && mem_rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && mem_rd_valid) begin
            ext_buf_wdata <= mem_rd_data;
        end
    end

    // Host must wait for busy low
    a_cmd_while_busy: assert property (@(posedge clk) disable iff (rst_nclk)
        cmd_valid |-> !busy);

    // Read length within one page
    a_read_wcnt: assert property (@(posedge clk) disable iff (rst_nclk)
        (cmd_valid && cmd.rd.op == CMD_READ) |->
            (cmd.rd.wcnt != '0 && cmd.rd.wcnt <= `PAGE_WORDS));

endmodule

//--- chnbuf_pkg.sv
//********************
// Channel-buffer-side types
// Word address, page index and full-page count of the double buffer
//********************
`include "mcont_settings.svh"

package chnbuf_pkg;

    // Word index within one page
    typedef logic [$clog2(`PAGE_WORDS)-1:0] waddr_t;

    // Page select of the double buffer
    typedef logic page_t;

    // Full pages held, 0 to 2
    typedef logic [1:0] pcnt_t;

    // Upper bound of the page count
    localparam pcnt_t PCNT_FULL = 2'd2;

endpackage

//--- mcont_cmd_pkg.sv
//********************
// Memory-controller-side types
// Channel number and the host command word with its two decodings
//********************
package mcont_cmd_pkg;

    // Field widths inside the 16-bit command word
    localparam int WCNT_W    = 6;
    localparam int REF_CNT_W = 14;

    // Channel number as carried on the buffer bus
    typedef logic [3:0] chn_t;

    // Opcode, top two bits of every command
    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,
        CMD_READ    = 2'd1,
        CMD_REFRESH = 2'd2
    } cmd_op_e;

    // Read view
    typedef struct packed {
        cmd_op_e           op;
        chn_t              chn;
        logic [WCNT_W-1:0] wcnt;
        logic [3:0]        pad;
    } cmd_rd_s;

    // Refresh view, same opcode position
    typedef struct packed {
        cmd_op_e              op;
        logic [REF_CNT_W-1:0] cycles;
    } cmd_ref_s;

    // One word, decoded by opcode
    typedef union packed {
        cmd_rd_s  rd;
        cmd_ref_s rf;
    } mcont_cmd_u;

endpackage

//--- mcont_settings.svh
//********************
// Build-wide sizes for the read path from the memory controller
// to the channel page buffers
// Included by RTL, packages and testbench alike
//********************
`ifndef MCONT_SETTINGS_SVH
`define MCONT_SETTINGS_SVH

// Channel blocks on the shared bus, at most 16
`define NUM_CHN 4

// Words per page, power of two
`define PAGE_WORDS 16

// Memory data word width
`define MCONT_DW 64

`endif
